//--- files.f
+incdir+hw
hw/gpio_pkg.sv
hw/bus_decoder.sv
hw/gpio_port.sv
hw/read_mux.sv
hw/button_debounce.sv
hw/gpio_bridge_top.sv
tests/gpio_checker.sv
tests/tb_gpio_bridge.sv

//--- hw/bus_decoder.sv
`timescale 1ns/1ps
`include "gpio_settings.svh"

module bus_decoder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         chip_sel,
    input  gpio_pkg::bus_req_t           req,
    output gpio_pkg::port_wr_t           port_wr,
    output logic [`GPIO_NUM_PORTS-1:0]   port_hit,
    output gpio_pkg::rd_sel_t            rd_sel
);

    // ==============================
    // access qualification
    // ==============================

    logic                       access;    // exactly one strobe with chip select
    logic                       wr_ok;     // write that lands in a port
    logic                       rd_acc;
    logic [`GPIO_IDX_WIDTH-1:0] idx;
    gpio_pkg::reg_sel_e         sel;

    assign access = chip_sel & (req.rd ^ req.wr);
    assign rd_acc = access & req.rd;
    assign idx    = req.addr[`GPIO_ADDR_WIDTH-1:`GPIO_SEL_WIDTH];
    assign sel    = gpio_pkg::reg_sel_e'(req.addr[`GPIO_SEL_WIDTH-1:0]);

    // only data and direction are writable, and only on a real port
    assign wr_ok = access && req.wr
                && (idx < `GPIO_IDX_WIDTH'(`GPIO_NUM_PORTS))
                && (sel == gpio_pkg::REG_DATA || sel == gpio_pkg::REG_DIR);

    // ==============================
    // registered outputs
    // ==============================

    logic                       wr_valid_q;
    gpio_pkg::reg_sel_e         wr_sel_q;
    logic [`GPIO_BUS_WIDTH-1:0] wr_data_q;
    logic [`GPIO_NUM_PORTS-1:0] hit_q;
    logic                       rd_valid_q;
    logic [`GPIO_IDX_WIDTH-1:0] rd_port_q;
    logic                       rd_keys_q;
    gpio_pkg::reg_sel_e         rd_reg_q;

    // strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_valid_q <= 1'b0;
            hit_q      <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            wr_valid_q <= wr_ok;
            rd_valid_q <= rd_acc;
            for (int p = 0; p < `GPIO_NUM_PORTS; p++) begin
                hit_q[p] <= wr_ok && (idx == `GPIO_IDX_WIDTH'(p)); // one-hot
            end
        end
    end

    // payload, only meaningful alongside its valid
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            wr_sel_q  <= sel;
            wr_data_q <= req.wdata;
        end
        if (rd_acc) begin
            rd_port_q <= idx;
            rd_keys_q <= (idx == `GPIO_IDX_WIDTH'(`GPIO_NUM_PORTS)); // button slot
            rd_reg_q  <= sel;
        end
    end

    assign port_wr  = '{valid: wr_valid_q, sel: wr_sel_q, data: wr_data_q};
    assign port_hit = hit_q;
    assign rd_sel   = '{valid: rd_valid_q, port: rd_port_q, keys: rd_keys_q, sel: rd_reg_q};

    // host never raises both strobes in one selected cycle
    a_one_strobe : assert property (@(posedge clk) disable iff (!rst_n)
        chip_sel |-> !(req.rd && req.wr))
        else $error("bus_decoder: rd and wr both high with chip_sel");

endmodule

//--- hw/button_debounce.sv
`timescale 1ns/1ps
`include "gpio_settings.svh"

module button_debounce (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`GPIO_NUM_KEYS-1:0]   keys,      // raw, bouncing
    output logic [`GPIO_NUM_KEYS-1:0]   keys_db
);

    localparam int unsigned CNT_W = $clog2(`GPIO_DEBOUNCE_CYCLES + 1);

    // ==============================
    // synchronizer
    // ==============================

    logic [`GPIO_NUM_KEYS-1:0] key_meta_q;
    logic [`GPIO_NUM_KEYS-1:0] key_sync_q;
    logic [`GPIO_NUM_KEYS-1:0] key_last_q;   // sync value one cycle back
    logic [CNT_W-1:0]          cnt_q;        // shared across all keys

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_meta_q <= '0;
            key_sync_q <= '0;
            key_last_q <= '0;
        end else begin
            key_meta_q <= keys;
            key_sync_q <= key_meta_q;
            key_last_q <= key_sync_q;
        end
    end

    // ==============================
    // stability counter
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q   <= '0;
            keys_db <= '0;
        end else if (key_sync_q == keys_db || key_sync_q != key_last_q) begin
            cnt_q <= '0;                            // settled or still bouncing
        end else if (cnt_q == CNT_W'(`GPIO_DEBOUNCE_CYCLES)) begin
            keys_db <= key_sync_q;                  // stable long enough
            cnt_q   <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    a_cnt_bound : assert property (@(posedge clk) disable iff (!rst_n)
        cnt_q <= CNT_W'(`GPIO_DEBOUNCE_CYCLES))
        else $error("button_debounce: counter past limit");

endmodule

//--- hw/gpio_bridge_top.sv
`timescale 1ns/1ps
`include "gpio_settings.svh"

module gpio_bridge_top (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // host bus
    input  logic                                          chip_sel,
    input  logic                                          rd,
    input  logic                                          wr,
    input  logic [`GPIO_ADDR_WIDTH-1:0]                   bus_addr,
    input  logic [`GPIO_BUS_WIDTH-1:0]                    bus_wdata,
    output logic [`GPIO_BUS_WIDTH-1:0]                    bus_rdata,
    // pins, port 0 in the low slice
    input  logic [`GPIO_NUM_PORTS*`GPIO_PORT_WIDTH-1:0]   pin_in,
    output logic [`GPIO_NUM_PORTS*`GPIO_PORT_WIDTH-1:0]   pin_out,
    output logic [`GPIO_NUM_PORTS*`GPIO_PORT_WIDTH-1:0]   pin_oe,
    // push buttons
    input  logic [`GPIO_NUM_KEYS-1:0]                     keys
);

    // ==============================
    // internal wiring
    // ==============================

    gpio_pkg::bus_req_t                           bus_req;
    gpio_pkg::port_wr_t                           port_wr;
    logic [`GPIO_NUM_PORTS-1:0]                   port_hit;
    gpio_pkg::rd_sel_t                            rd_sel;
    gpio_pkg::port_view_t [`GPIO_NUM_PORTS-1:0]   views;
    logic [`GPIO_NUM_KEYS-1:0]                    keys_db;

    assign bus_req = '{rd: rd, wr: wr, addr: bus_addr, wdata: bus_wdata};

    bus_decoder bus_decoder_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .chip_sel (chip_sel),
        .req      (bus_req),
        .port_wr  (port_wr),
        .port_hit (port_hit),
        .rd_sel   (rd_sel)
    );

    // one port per slice of the pin vectors
    genvar g;
    generate
        for (g = 0; g < `GPIO_NUM_PORTS; g++) begin : port_loop
            gpio_port gpio_port_inst (
                .clk     (clk),
                .rst_n   (rst_n),
                .port_wr (port_wr),                                   // broadcast
                .hit     (port_hit[g]),
                .pin_in  (pin_in[g*`GPIO_PORT_WIDTH +: `GPIO_PORT_WIDTH]),
                .pin_out (pin_out[g*`GPIO_PORT_WIDTH +: `GPIO_PORT_WIDTH]),
                .pin_oe  (pin_oe[g*`GPIO_PORT_WIDTH +: `GPIO_PORT_WIDTH]),
                .view    (views[g])
            );
        end
    endgenerate

    read_mux read_mux_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_sel    (rd_sel),
        .views     (views),
        .keys_db   (keys_db),
        .bus_rdata (bus_rdata)
    );

    button_debounce button_debounce_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .keys    (keys),
        .keys_db (keys_db)
    );

endmodule

//--- hw/gpio_pkg.sv
`include "gpio_settings.svh"

package gpio_pkg;

    // ==============================
    // address decode
    // ==============================

    // low address bits pick the register inside a port
    typedef enum logic [`GPIO_SEL_WIDTH-1:0] {
        REG_DATA = 2'd0,   // output data
        REG_DIR  = 2'd1,   // direction, 1 drives the pin
        REG_PINS = 2'd2,   // synchronized pin inputs, read only
        REG_KEYS = 2'd3    // debounced buttons, only at index NUM_PORTS
    } reg_sel_e;

    // ==============================
    // bridge internal traffic
    // ==============================

    // raw bus access as seen at the pins of the bridge
    typedef struct packed {
        logic                        rd;
        logic                        wr;
        logic [`GPIO_ADDR_WIDTH-1:0] addr;
        logic [`GPIO_BUS_WIDTH-1:0]  wdata;
    } bus_req_t;

    // registered write, broadcast to every port
    typedef struct packed {
        logic                       valid;   // mapped, writable register
        reg_sel_e                   sel;
        logic [`GPIO_BUS_WIDTH-1:0] data;
    } port_wr_t;

    // registered read, consumed by the read mux
    typedef struct packed {
        logic                       valid;
        logic [`GPIO_IDX_WIDTH-1:0] port;
        logic                       keys;    // index hits the button slot
        reg_sel_e                   sel;
    } rd_sel_t;

    // what one port shows to the host
    typedef struct packed {
        logic [`GPIO_PORT_WIDTH-1:0] data;
        logic [`GPIO_PORT_WIDTH-1:0] dir;
        logic [`GPIO_PORT_WIDTH-1:0] pins;
    } port_view_t;

endpackage

//--- hw/gpio_port.sv
`timescale 1ns/1ps
`include "gpio_settings.svh"

module gpio_port (
    input  logic                          clk,
    input  logic                          rst_n,
    input  gpio_pkg::port_wr_t            port_wr,
    input  logic                          hit,       // this port addressed
    input  logic [`GPIO_PORT_WIDTH-1:0]   pin_in,
    output logic [`GPIO_PORT_WIDTH-1:0]   pin_out,
    output logic [`GPIO_PORT_WIDTH-1:0]   pin_oe,
    output gpio_pkg::port_view_t          view
);

    // ==============================
    // host registers
    // ==============================

    logic [`GPIO_PORT_WIDTH-1:0] data_q;   // output value
    logic [`GPIO_PORT_WIDTH-1:0] dir_q;    // 1 = output
    logic                        load;

    assign load = hit & port_wr.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_q <= '0;
            dir_q  <= '0;
        end else if (load) begin
            case (port_wr.sel)
                gpio_pkg::REG_DATA: data_q <= port_wr.data;
                gpio_pkg::REG_DIR:  dir_q  <= port_wr.data;
                default: ;                  // read-only, filtered upstream
            endcase
        end
    end

    // ==============================
    // pin side
    // ==============================

    // board wrapper builds the tristates from these
    assign pin_out = data_q;
    assign pin_oe  = dir_q;

    logic [`GPIO_PORT_WIDTH-1:0] pin_meta_q;  // first stage, may go metastable
    logic [`GPIO_PORT_WIDTH-1:0] pin_sync_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pin_meta_q <= '0;
            pin_sync_q <= '0;
        end else begin
            pin_meta_q <= pin_in;
            pin_sync_q <= pin_meta_q;
        end
    end

    // read-back view for the mux
    assign view = '{data: data_q, dir: dir_q, pins: pin_sync_q};

    // output enables move only as the result of a direction write
    a_oe_from_dir : assert property (@(posedge clk) disable iff (!rst_n)
        $changed(pin_oe) |->
            $past(hit && port_wr.valid && port_wr.sel == gpio_pkg::REG_DIR))
        else $error("gpio_port: pin_oe changed without a REG_DIR write");

endmodule

//--- hw/gpio_settings.svh
`ifndef GPIO_SETTINGS_SVH
`define GPIO_SETTINGS_SVH

// ==============================
// bridge geometry
// ==============================

// identical gpio ports behind the bridge
`define GPIO_NUM_PORTS 2

// pins per port
`define GPIO_PORT_WIDTH 32

// host data bus width
`define GPIO_BUS_WIDTH 32

// word address, port index on top, register select in the low bits
`define GPIO_ADDR_WIDTH 6
`define GPIO_SEL_WIDTH 2
`define GPIO_IDX_WIDTH (`GPIO_ADDR_WIDTH - `GPIO_SEL_WIDTH)

// ==============================
// push buttons
// ==============================

`define GPIO_NUM_KEYS 2

// stable cycles before the debounced value follows
`define GPIO_DEBOUNCE_CYCLES 16

`endif

//--- hw/read_mux.sv
`timescale 1ns/1ps
`include "gpio_settings.svh"

module read_mux (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  gpio_pkg::rd_sel_t                             rd_sel,
    input  gpio_pkg::port_view_t [`GPIO_NUM_PORTS-1:0]    views,
    input  logic [`GPIO_NUM_KEYS-1:0]                     keys_db,
    output logic [`GPIO_BUS_WIDTH-1:0]                    bus_rdata
);

    // ==============================
    // word select
    // ==============================

    logic [`GPIO_BUS_WIDTH-1:0] rd_word;

    always_comb begin
        rd_word = '0;                                  // unmapped reads give zero
        if (rd_sel.keys) begin
            if (rd_sel.sel == gpio_pkg::REG_KEYS) begin
                rd_word = {{(`GPIO_BUS_WIDTH-`GPIO_NUM_KEYS){1'b0}}, keys_db};
            end
        end else begin
            for (int p = 0; p < `GPIO_NUM_PORTS; p++) begin
                if (rd_sel.port == `GPIO_IDX_WIDTH'(p)) begin
                    case (rd_sel.sel)
                        gpio_pkg::REG_DATA: rd_word = views[p].data;
                        gpio_pkg::REG_DIR:  rd_word = views[p].dir;
                        gpio_pkg::REG_PINS: rd_word = views[p].pins;
                        default:            rd_word = '0;  // keys only at its slot
                    endcase
                end
            end
        end
    end

    // ==============================
    // bus register
    // ==============================

    // holds the last read until the next one completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_rdata <= '0;
        end else if (rd_sel.valid) begin
            bus_rdata <= rd_word;
        end
    end

endmodule

//--- tests/gpio_checker.sv
`timescale 1ns/1ps
`include "gpio_settings.svh"

module gpio_checker (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // dut0 outputs
    input  logic [`GPIO_BUS_WIDTH-1:0]                    bus_rdata,
    input  logic [`GPIO_NUM_PORTS*`GPIO_PORT_WIDTH-1:0]   pin_out,
    input  logic [`GPIO_NUM_PORTS*`GPIO_PORT_WIDTH-1:0]   pin_oe,
    // expectations from the stimulus, valid in the issue cycle
    input  logic                                          rd_chk,
    input  logic [`GPIO_BUS_WIDTH-1:0]                    rd_exp,
    input  logic                                          pin_chk,
    input  logic [`GPIO_NUM_PORTS*`GPIO_PORT_WIDTH-1:0]   exp_out,
    input  logic [`GPIO_NUM_PORTS*`GPIO_PORT_WIDTH-1:0]   exp_oe,
    input  logic                                          test_done,
    input  int                                            test_num,
    input  logic                                          all_done,
    output int                                            err_total
);

    localparam int BW = `GPIO_BUS_WIDTH;
    localparam int PV = `GPIO_NUM_PORTS * `GPIO_PORT_WIDTH;

    // ==============================
    // two-edge delay line
    // ==============================

    logic          rd_q1;
    logic          rd_q2;
    logic [BW-1:0] rdx_q1;
    logic [BW-1:0] rdx_q2;
    logic          pin_q1;
    logic          pin_q2;
    logic [PV-1:0] out_q1;
    logic [PV-1:0] out_q2;
    logic [PV-1:0] oe_q1;
    logic [PV-1:0] oe_q2;
    logic          done_q;
    int            num_q;
    logic          fin_q;
    int            chk_test;
    int            err_test;
    int            chk_total;

    initial begin
        chk_test  = 0;
        err_test  = 0;
        chk_total = 0;
        err_total = 0;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q1  <= 1'b0;
            rd_q2  <= 1'b0;
            pin_q1 <= 1'b0;
            pin_q2 <= 1'b0;
            done_q <= 1'b0;
            fin_q  <= 1'b0;
        end else begin
            rd_q1  <= rd_chk;
            rdx_q1 <= rd_exp;
            rd_q2  <= rd_q1;
            rdx_q2 <= rdx_q1;
            pin_q1 <= pin_chk;
            out_q1 <= exp_out;
            oe_q1  <= exp_oe;
            pin_q2 <= pin_q1;
            out_q2 <= out_q1;
            oe_q2  <= oe_q1;
            done_q <= test_done;
            num_q  <= test_num;
            fin_q  <= all_done & ~fin_q;   // one closing line
        end
    end

    // ==============================
    // compare, mid-cycle
    // ==============================

    always @(negedge clk) begin
        if (rd_q2) begin
            chk_test++;
            if (bus_rdata !== rdx_q2) begin
                err_test++;
                err_total++;
                $display("MISMATCH at %0t: bus_rdata %h, expected %h", $time, bus_rdata, rdx_q2);
            end
        end
        if (pin_q2) begin
            chk_test++;
            if (pin_out !== out_q2 || pin_oe !== oe_q2) begin
                err_test++;
                err_total++;
                $display("MISMATCH at %0t: pin_out %h pin_oe %h, expected %h %h",
                         $time, pin_out, pin_oe, out_q2, oe_q2);
            end
        end
        if (done_q) begin
            $display("test %0d finished: %0d checks, %0d mismatches", num_q, chk_test, err_test);
            chk_total += chk_test;
            chk_test   = 0;
            err_test   = 0;
        end
        if (fin_q) begin
            $display("all tests: %0d checks, %0d mismatches", chk_total, err_total);
        end
    end

endmodule

//--- tests/tb_gpio_bridge.sv
`timescale 1ns/1ps
`include "gpio_settings.svh"

module tb_gpio_bridge;

    localparam int NP = `GPIO_NUM_PORTS;
    localparam int PW = `GPIO_PORT_WIDTH;
    localparam int BW = `GPIO_BUS_WIDTH;
    localparam int AW = `GPIO_ADDR_WIDTH;
    localparam int NK = `GPIO_NUM_KEYS;
    localparam int DB = `GPIO_DEBOUNCE_CYCLES;
    localparam int N_IDX = 1 << `GPIO_IDX_WIDTH;   // port index slots in the map

    // ==============================
    // test lengths in cycles
    // ==============================

    localparam int N_RW      = 40;
    localparam int N_PIN     = 8;
    localparam int N_IGN     = 12;
    localparam int N_KEY     = 4;
    localparam int LEN_RESET = 20;
    localparam int LEN_RW    = 3 * N_RW + 10;
    localparam int LEN_PIN   = 6 * N_PIN + 10;
    localparam int LEN_IGN   = 3 * N_IGN + 10;
    localparam int LEN_KEY   = N_KEY * (DB / 2 + 2 * (DB + 6) + 4) + 10;
    localparam int CYCLE_LIMIT = (LEN_RESET + LEN_RW + LEN_PIN + LEN_IGN + LEN_KEY) * 3 / 2;

    logic              clk;
    logic              rst_n;
    logic              chip_sel;
    logic              rd;
    logic              wr;
    logic [AW-1:0]     bus_addr;
    logic [BW-1:0]     bus_wdata;
    logic [BW-1:0]     bus_rdata;
    logic [NP*PW-1:0]  pin_in;
    logic [NP*PW-1:0]  pin_out;
    logic [NP*PW-1:0]  pin_oe;
    logic [NK-1:0]     keys;

    // expectations handed to the checker
    logic              rd_chk;
    logic [BW-1:0]     rd_exp;
    logic [BW-1:0]     last_rd;    // word the bus holds after the latest real read
    logic              pin_chk;
    logic [NP*PW-1:0]  exp_out;
    logic [NP*PW-1:0]  exp_oe;
    logic              test_done;
    int                test_num;
    logic              all_done;
    int                err_total;

    // register model
    logic [PW-1:0]     m_data [NP];
    logic [PW-1:0]     m_dir [NP];
    logic [NK-1:0]     exp_keys;   // debounced value the host should see
    integer            seed;
    int                cycles = 0;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    gpio_bridge_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .chip_sel  (chip_sel),
        .rd        (rd),
        .wr        (wr),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .pin_in    (pin_in),
        .pin_out   (pin_out),
        .pin_oe    (pin_oe),
        .keys      (keys)
    );

    gpio_checker chk0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_rdata (bus_rdata),
        .pin_out   (pin_out),
        .pin_oe    (pin_oe),
        .rd_chk    (rd_chk),
        .rd_exp    (rd_exp),
        .pin_chk   (pin_chk),
        .exp_out   (exp_out),
        .exp_oe    (exp_oe),
        .test_done (test_done),
        .test_num  (test_num),
        .all_done  (all_done),
        .err_total (err_total)
    );

    // ==============================
    // reference model
    // ==============================

    function automatic logic [AW-1:0] make_addr(input int idx, input gpio_pkg::reg_sel_e sel);
        return (AW'(idx) << `GPIO_SEL_WIDTH) | AW'(sel);
    endfunction

    // applies a write by the address rules, returns what a read must give
    function automatic logic [BW-1:0] ref_access(input logic r, input logic w,
                                                 input logic [AW-1:0] addr,
                                                 input logic [BW-1:0] wdata);
        int                 idx;
        gpio_pkg::reg_sel_e sel;
        logic [BW-1:0]      word;
        idx  = int'(addr >> `GPIO_SEL_WIDTH);
        sel  = gpio_pkg::reg_sel_e'(addr[`GPIO_SEL_WIDTH-1:0]);
        word = '0;
        if (w && idx < NP) begin
            if (sel == gpio_pkg::REG_DATA) m_data[idx] = wdata;
            if (sel == gpio_pkg::REG_DIR)  m_dir[idx]  = wdata;
        end else if (r && idx < NP) begin
            case (sel)
                gpio_pkg::REG_DATA: word = m_data[idx];
                gpio_pkg::REG_DIR:  word = m_dir[idx];
                gpio_pkg::REG_PINS: word = pin_in[idx*PW +: PW];
                default:            word = '0;
            endcase
        end else if (r && idx == NP && sel == gpio_pkg::REG_KEYS) begin
            word = {{(BW-NK){1'b0}}, exp_keys};
        end
        return word;
    endfunction

    // ==============================
    // bus driving, falling edge
    // ==============================

    task automatic load_pin_exp();
        int p;
        for (p = 0; p < NP; p++) begin
            exp_out[p*PW +: PW] = m_data[p];
            exp_oe[p*PW +: PW]  = m_dir[p];
        end
    endtask

    task automatic bus_cycle(input logic cs, input logic r, input logic w,
                             input logic [AW-1:0] addr, input logic [BW-1:0] wdata);
        logic [BW-1:0] word;
        @(negedge clk);
        word = '0;
        if (cs && (r ^ w)) word = ref_access(r, w, addr, wdata);
        if (cs && r && !w) last_rd = word;
        chip_sel  = cs;
        rd        = r;
        wr        = w;
        bus_addr  = addr;
        bus_wdata = wdata;
        rd_chk    = ~cs | (r & ~w);   // deselected access must leave bus_rdata alone
        rd_exp    = last_rd;
        pin_chk   = w;                // pins checked after any write attempt
        load_pin_exp();
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            chip_sel = 1'b0;
            rd       = 1'b0;
            wr       = 1'b0;
            rd_chk   = 1'b0;
            pin_chk  = 1'b0;
        end
    endtask

    task automatic pin_probe();
        idle(1);
        pin_chk = 1'b1;
        load_pin_exp();
    endtask

    // drain the pipeline, then let the checker report
    task automatic finish_test(input int n);
        idle(3);
        test_num  = n;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ==============================
    // stimulus
    // ==============================

    initial begin
        int                 i;
        int                 port;
        int                 idx;
        int                 len;
        logic [BW-1:0]      val;
        logic [NK-1:0]      knew;
        gpio_pkg::reg_sel_e sel;
        seed      = 32'hc6cb;
        rst_n     = 1'b0;
        chip_sel  = 1'b0;
        rd        = 1'b0;
        wr        = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        pin_in    = '0;
        keys      = '0;
        rd_chk    = 1'b0;
        rd_exp    = '0;
        last_rd   = '0;
        pin_chk   = 1'b0;
        exp_out   = '0;
        exp_oe    = '0;
        test_done = 1'b0;
        test_num  = 0;
        all_done  = 1'b0;
        exp_keys  = '0;
        for (i = 0; i < NP; i++) begin
            m_data[i] = '0;
            m_dir[i]  = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;

        // test 1, reset values
        pin_probe();
        for (i = 0; i < NP; i++) begin
            bus_cycle(1'b1, 1'b1, 1'b0, make_addr(i, gpio_pkg::REG_DATA), '0);
            bus_cycle(1'b1, 1'b1, 1'b0, make_addr(i, gpio_pkg::REG_DIR), '0);
        end
        bus_cycle(1'b1, 1'b1, 1'b0, make_addr(NP, gpio_pkg::REG_KEYS), '0);
        finish_test(1);

        // test 2, random data and direction writes
        for (i = 0; i < N_RW; i++) begin
            port = {$random(seed)} % NP;
            sel  = ($random(seed) & 1) ? gpio_pkg::REG_DIR : gpio_pkg::REG_DATA;
            val  = $random(seed);
            bus_cycle(1'b1, 1'b0, 1'b1, make_addr(port, sel), val);
            if ($random(seed) & 1) begin
                bus_cycle(1'b1, 1'b1, 1'b0, make_addr(port, sel), '0);  // right behind
            end else begin
                idle(1);
                port = {$random(seed)} % NP;
                sel  = gpio_pkg::reg_sel_e'({$random(seed)} % 2);
                bus_cycle(1'b1, 1'b1, 1'b0, make_addr(port, sel), '0);
            end
        end
        finish_test(2);

        // test 3, pin inputs through the synchronizer
        for (i = 0; i < N_PIN; i++) begin
            idle(1);
            for (port = 0; port < NP; port++) pin_in[port*PW +: PW] = $random(seed);
            idle(3);                                           // settle past both flops
            for (port = 0; port < NP; port++) begin
                bus_cycle(1'b1, 1'b1, 1'b0, make_addr(port, gpio_pkg::REG_PINS), '0);
            end
        end
        finish_test(3);

        // test 4, accesses that must change nothing
        for (i = 0; i < N_IGN; i++) begin
            port = {$random(seed)} % NP;
            idx  = NP + {$random(seed)} % (N_IDX - NP);
            sel  = gpio_pkg::reg_sel_e'({$random(seed)} % 4);
            val  = $random(seed);
            case ({$random(seed)} % 3)
                0:       bus_cycle(1'b1, 1'b0, 1'b1, make_addr(port, gpio_pkg::REG_PINS), val);
                1:       bus_cycle(1'b1, 1'b0, 1'b1, make_addr(idx, sel), val);
                default: bus_cycle(1'b0, val[0], ~val[0], make_addr(port, gpio_pkg::REG_DATA), val);
            endcase
            bus_cycle(1'b1, 1'b1, 1'b0, make_addr(port, gpio_pkg::REG_DATA), '0);
            bus_cycle(1'b1, 1'b1, 1'b0, make_addr(idx, sel), '0);   // unmapped or keys
        end
        finish_test(4);

        // test 5, debounced buttons
        for (i = 0; i < N_KEY; i++) begin
            knew = exp_keys ^ NK'({$random(seed)} % ((1 << NK) - 1) + 1);
            len  = 1 + {$random(seed)} % (DB / 2 - 1);
            idle(1);
            keys = knew;                                       // short glitch
            repeat (len) bus_cycle(1'b1, 1'b1, 1'b0, make_addr(NP, gpio_pkg::REG_KEYS), '0);
            keys = exp_keys;
            // glitch must never show, polled every cycle
            repeat (DB + 7) bus_cycle(1'b1, 1'b1, 1'b0, make_addr(NP, gpio_pkg::REG_KEYS), '0);
            idle(1);
            keys = knew;                                       // real press
            idle(DB + 6);
            exp_keys = knew;
            bus_cycle(1'b1, 1'b1, 1'b0, make_addr(NP, gpio_pkg::REG_KEYS), '0);
        end
        finish_test(5);

        all_done = 1'b1;
        @(negedge clk);
        @(negedge clk);                                        // counts line first
        if (err_total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
